// ==== hw/ac97_pkg.sv ====
// ac97 shared definitions
// frame geometry, slot positions, codec register map and command word layout
package ac97_pkg;

  ////////////////////////////////////////
  // frame geometry
  ////////////////////////////////////////

  // one frame is 256 bit clocks long
  localparam int FRAME_BITS = 256;
  // data slots are 20 bits, the tag slot is 16
  localparam int SLOT_BITS = 20;
  localparam int TAG_BITS = 16;

  // first frame bit of each data slot
  localparam int SLOT1_START = 16;
  localparam int SLOT2_START = 36;
  localparam int SLOT3_START = 56;
  localparam int SLOT4_START = 76;

  // frame bit of the once-per-frame sample strobe
  localparam int READY_BIT = 128;

  // user side sample and volume widths
  localparam int SAMPLE_WIDTH = 8;
  localparam int VOLUME_WIDTH = 5;
  localparam int VOLUME_MAX = 31;

  // entries in the repeating command list
  localparam int CMD_STATES = 16;

  ////////////////////////////////////////
  // codec register map
  ////////////////////////////////////////

  localparam logic [7:0] REG_HEADPHONE = 8'h04;
  localparam logic [7:0] REG_PCM_VOL = 8'h18;
  localparam logic [7:0] REG_REC_SELECT = 8'h1A;
  localparam logic [7:0] REG_REC_GAIN = 8'h1C;
  localparam logic [7:0] REG_MIC = 8'h0E;
  localparam logic [7:0] REG_BEEP = 8'h0A;
  localparam logic [7:0] REG_GENERAL = 8'h20;
  // bit 7 set turns the access into a read, here of the vendor id
  localparam logic [7:0] REG_READ_ID = 8'h80;

  // register write data
  localparam logic [15:0] PCM_VOL_DATA = 16'h0808;
  // record gain at max on both channels
  localparam logic [15:0] REC_GAIN_DATA = 16'h0F0F;
  // mic boost +20 dB
  localparam logic [15:0] MIC_DATA = 16'h8048;
  localparam logic [15:0] BEEP_DATA = 16'h0000;
  // pcm out bypasses mix 1
  localparam logic [15:0] GENERAL_DATA = 16'h8000;

  ////////////////////////////////////////
  // command word
  ////////////////////////////////////////

  // built whole by the sequencer, split into slot 1 and slot 2 by the frame engine
  typedef union packed {
    logic [23:0] raw;
    struct packed {
      logic [7:0] addr;
      logic [15:0] data;
    } field;
  } ac97_cmd_t;

endpackage

// ==== hw/debounce.sv ====
// switch debouncer
// passes the input on once it has been stable for a set number of cycles
module debounce #(
  parameter int DEBOUNCE_COUNT = 270000
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int COUNT_W = $clog2(DEBOUNCE_COUNT + 1);
  localparam logic [COUNT_W-1:0] STABLE_AT = COUNT_W'(DEBOUNCE_COUNT);

  // last value seen on the input
  logic last_seen;
  // cycles since the last change
  logic [COUNT_W-1:0] count;

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
      last_seen <= noisy;
      clean <= noisy;
    end else if (noisy != last_seen) begin
      // input moved, start the stability window over
      last_seen <= noisy;
      count <= '0;
    end else if (count == STABLE_AT) begin
      // stable long enough
      clean <= last_seen;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== hw/volume_control.sv ====
// headphone volume register
// two debounced buttons step a saturating volume up and down
module volume_control
  import ac97_pkg::*;
#(
  parameter int DEBOUNCE_COUNT = 270000,
  parameter int VOLUME_AT_RESET = 8
) (
  input  logic clock,
  input  logic reset,
  input  logic button_up,
  input  logic button_down,
  output logic [VOLUME_WIDTH-1:0] volume
);

  localparam logic [VOLUME_WIDTH-1:0] VOL_TOP = VOLUME_WIDTH'(VOLUME_MAX);
  localparam logic [VOLUME_WIDTH-1:0] VOL_INIT = VOLUME_WIDTH'(VOLUME_AT_RESET);

  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;
  logic up_edge;
  logic down_edge;

  debounce #(.DEBOUNCE_COUNT(DEBOUNCE_COUNT)) u_up (
    .clock(clock),
    .reset(reset),
    .noisy(button_up),
    .clean(up_clean)
  );

  debounce #(.DEBOUNCE_COUNT(DEBOUNCE_COUNT)) u_down (
    .clock(clock),
    .reset(reset),
    .noisy(button_down),
    .clean(down_clean)
  );

  // one cycle delayed copies for press detection
  always_ff @(posedge clock) begin
    up_prev <= up_clean;
    down_prev <= down_clean;
  end

  assign up_edge = up_clean & ~up_prev;
  assign down_edge = down_clean & ~down_prev;

  // down wins a tie, except at the bottom where it would do nothing
  always_ff @(posedge clock) begin
    if (reset) begin
      volume <= VOL_INIT;
    end else if (down_edge && volume != '0) begin
      volume <= volume - 1'b1;
    end else if (up_edge && volume != VOL_TOP) begin
      volume <= volume + 1'b1;
    end
  end

endmodule

// ==== hw/ac97_command_seq.sv ====
// codec command sequencer
// steps through a fixed list of register writes and reads, one per frame
module ac97_command_seq
  import ac97_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic sample_ready,
  input  logic [VOLUME_WIDTH-1:0] volume,
  output ac97_cmd_t command,
  output logic command_valid
);

  localparam int STATE_W = $clog2(CMD_STATES);
  localparam logic [VOLUME_WIDTH-1:0] VOL_TOP = VOLUME_WIDTH'(VOLUME_MAX);

  logic [STATE_W-1:0] state;
  // headphone attenuation, 0 is loudest
  logic [VOLUME_WIDTH-1:0] atten;
  ac97_cmd_t entry;

  ////////////////////////////////////////
  // state counter
  ////////////////////////////////////////

  // list length is a power of two so the counter wraps on its own
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= '0;
      command_valid <= 1'b0;
    end else begin
      command_valid <= 1'b1;
      if (sample_ready) begin
        state <= state + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // command table
  ////////////////////////////////////////

  assign atten = VOL_TOP - volume;

  always_comb begin
    case (state)
      // same attenuation on left and right
      4'd3: entry.raw = {REG_HEADPHONE, 3'b000, atten, 3'b000, atten};
      4'd5: entry.raw = {REG_PCM_VOL, PCM_VOL_DATA};
      // record source 0 selects the mic on both channels
      4'd6: entry.raw = {REG_REC_SELECT, 16'h0000};
      4'd7: entry.raw = {REG_REC_GAIN, REC_GAIN_DATA};
      4'd9: entry.raw = {REG_MIC, MIC_DATA};
      4'd10: entry.raw = {REG_BEEP, BEEP_DATA};
      4'd11: entry.raw = {REG_GENERAL, GENERAL_DATA};
      // idle slots just read the id
      default: entry.raw = {REG_READ_ID, 16'h0000};
    endcase
  end

  // command lags the state by one cycle
  always_ff @(posedge clock) begin
    command <= entry;
  end

endmodule

// ==== hw/ac97_frame.sv ====
// ac97 frame engine
// holds the codec in reset, then serializes output frames and captures the left input slot
module ac97_frame
  import ac97_pkg::*;
#(
  parameter int CODEC_RESET_CYCLES = 1023
) (
  input  logic clock,
  input  logic reset,
  input  ac97_cmd_t command,
  input  logic command_valid,
  input  logic [SAMPLE_WIDTH-1:0] audio_out_data,
  input  logic sdata_in,
  output logic [SAMPLE_WIDTH-1:0] audio_in_data,
  output logic sample_ready,
  output logic audio_reset_b,
  output logic sync,
  output logic sdata_out
);

  localparam int HOLD_W = $clog2(CODEC_RESET_CYCLES + 1);
  localparam int COUNT_W = $clog2(FRAME_BITS);
  localparam int TAG_W = $clog2(TAG_BITS);
  // slots 1 to 4 back to back
  localparam int PAYLOAD_BITS = SLOT4_START + SLOT_BITS - SLOT1_START;
  localparam int PAYLOAD_W = $clog2(PAYLOAD_BITS);

  // bit counter values, outputs show up one cycle after the count that produced them
  localparam logic [HOLD_W-1:0] HOLD_DONE = HOLD_W'(CODEC_RESET_CYCLES);
  localparam logic [COUNT_W-1:0] LAST_BIT = COUNT_W'(FRAME_BITS - 1);
  localparam logic [COUNT_W-1:0] TAG_END = COUNT_W'(TAG_BITS);
  localparam logic [COUNT_W-1:0] TAG_LAST = COUNT_W'(TAG_BITS - 1);
  localparam logic [COUNT_W-1:0] PAYLOAD_LAST = COUNT_W'(SLOT4_START + SLOT_BITS - 1);
  localparam logic [COUNT_W-1:0] STROBE_AT = COUNT_W'(READY_BIT);
  // input is sampled at the end of each slot 3 bit time
  localparam logic [COUNT_W-1:0] CAPTURE_FIRST = COUNT_W'(SLOT3_START + 1);
  localparam logic [COUNT_W-1:0] CAPTURE_LAST = COUNT_W'(SLOT3_START + SLOT_BITS);

  logic [HOLD_W-1:0] hold_count;
  logic [COUNT_W-1:0] bit_count;

  // frame contents latched at the end of the previous frame
  logic cmd_v_l;
  logic audio_v_l;
  logic [7:0] cmd_addr_l;
  logic [15:0] cmd_data_l;
  logic [SAMPLE_WIDTH-1:0] sample_l;

  logic [TAG_BITS-1:0] tag_bits;
  logic [TAG_W-1:0] tag_index;
  logic [SLOT_BITS-1:0] addr_slot;
  logic [SLOT_BITS-1:0] data_slot;
  logic [SLOT_BITS-1:0] audio_slot;
  logic [PAYLOAD_BITS-1:0] payload_bits;
  logic [PAYLOAD_W-1:0] payload_index;
  logic [SLOT_BITS-1:0] left_in;

  ////////////////////////////////////////
  // codec reset hold
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_count <= '0;
      audio_reset_b <= 1'b0;
    end else if (!audio_reset_b) begin
      if (hold_count == HOLD_DONE) begin
        audio_reset_b <= 1'b1;
      end else begin
        hold_count <= hold_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // frame assembly
  ////////////////////////////////////////

  // tag in frame order, msb goes out first
  always_comb begin
    tag_bits = '0;
    // frame valid
    tag_bits[TAG_BITS-1] = 1'b1;
    // command address and data valid
    tag_bits[TAG_BITS-2] = cmd_v_l;
    tag_bits[TAG_BITS-3] = cmd_v_l;
    // left and right audio valid
    tag_bits[TAG_BITS-4] = audio_v_l;
    tag_bits[TAG_BITS-5] = audio_v_l;
  end

  // slots left justified, empty until the first latch
  assign addr_slot = cmd_v_l ? {cmd_addr_l, 12'h000} : '0;
  assign data_slot = cmd_v_l ? {cmd_data_l, 4'h0} : '0;
  assign audio_slot = audio_v_l ? {sample_l, {(SLOT_BITS - SAMPLE_WIDTH){1'b0}}} : '0;
  // mono playback, right copies left
  assign payload_bits = {addr_slot, data_slot, audio_slot, audio_slot};

  assign tag_index = TAG_W'(TAG_LAST - bit_count);
  assign payload_index = PAYLOAD_W'(PAYLOAD_LAST - bit_count);

  ////////////////////////////////////////
  // bit counter and serializer
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset || !audio_reset_b) begin
      bit_count <= '0;
      sync <= 1'b0;
      sdata_out <= 1'b0;
      sample_ready <= 1'b0;
      cmd_v_l <= 1'b0;
      audio_v_l <= 1'b0;
    end else begin
      bit_count <= bit_count + 1'b1;
      // sync covers the tag slot
      sync <= bit_count < TAG_END;
      sample_ready <= bit_count == STROBE_AT;
      if (bit_count < TAG_END) begin
        sdata_out <= tag_bits[tag_index];
      end else if (bit_count <= PAYLOAD_LAST) begin
        sdata_out <= payload_bits[payload_index];
      end else begin
        sdata_out <= 1'b0;
      end
      if (bit_count == LAST_BIT) begin
        cmd_v_l <= command_valid;
        // audio is always valid once the first frame has gone out
        audio_v_l <= 1'b1;
      end
    end
  end

  // user values are taken once per frame
  always_ff @(posedge clock) begin
    if (bit_count == LAST_BIT) begin
      cmd_addr_l <= command.field.addr;
      cmd_data_l <= command.field.data;
      sample_l <= audio_out_data;
    end
  end

  ////////////////////////////////////////
  // left input capture
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (bit_count >= CAPTURE_FIRST && bit_count <= CAPTURE_LAST) begin
      left_in <= {left_in[SLOT_BITS-2:0], sdata_in};
    end
  end

  // top bits of the 20 bit sample
  assign audio_in_data = left_in[SLOT_BITS-1 -: SAMPLE_WIDTH];

endmodule

// ==== hw/audio_codec_top.sv ====
// ac97 audio codec controller
// volume buttons, command sequencer and frame engine
module audio_codec_top
  import ac97_pkg::*;
#(
  parameter int DEBOUNCE_COUNT = 270000,
  parameter int CODEC_RESET_CYCLES = 1023,
  parameter int VOLUME_AT_RESET = 8
) (
  input  logic clock,
  input  logic reset,
  input  logic button_up,
  input  logic button_down,
  input  logic [SAMPLE_WIDTH-1:0] audio_out_data,
  output logic [SAMPLE_WIDTH-1:0] audio_in_data,
  output logic sample_ready,
  output logic audio_reset_b,
  output logic sync,
  output logic sdata_out,
  input  logic sdata_in
);

  logic [VOLUME_WIDTH-1:0] volume;
  ac97_cmd_t command;
  logic command_valid;

  volume_control #(
    .DEBOUNCE_COUNT(DEBOUNCE_COUNT),
    .VOLUME_AT_RESET(VOLUME_AT_RESET)
  ) u_volume (
    .clock(clock),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .volume(volume)
  );

  // advances once per frame on the strobe
  ac97_command_seq u_cmd (
    .clock(clock),
    .reset(reset),
    .sample_ready(sample_ready),
    .volume(volume),
    .command(command),
    .command_valid(command_valid)
  );

  ac97_frame #(
    .CODEC_RESET_CYCLES(CODEC_RESET_CYCLES)
  ) u_frame (
    .clock(clock),
    .reset(reset),
    .command(command),
    .command_valid(command_valid),
    .audio_out_data(audio_out_data),
    .sdata_in(sdata_in),
    .audio_in_data(audio_in_data),
    .sample_ready(sample_ready),
    .audio_reset_b(audio_reset_b),
    .sync(sync),
    .sdata_out(sdata_out)
  );

endmodule

// ==== sim/audio_codec_chk.sv ====
// frame protocol checker
// bound into the codec top level, watches sync, strobe and codec reset
module audio_codec_chk (
  input logic clock,
  input logic reset,
  input logic audio_reset_b,
  input logic sync,
  input logic sdata_out,
  input logic sample_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  // sync high cycles in a row before this one
  logic [7:0] sync_run;

  always_ff @(posedge clock) begin
    if (reset) begin
      sync_run <= '0;
    end else if (sync) begin
      sync_run <= sync_run + 8'd1;
    end else begin
      sync_run <= '0;
    end
  end

  // sync never runs past the tag slot
  sync_max: assert property (@(posedge clock) disable iff (reset)
    sync |-> sync_run < 8'd16)
    else $error("sync high for more than 16 cycles");

  // and never drops before the tag slot ends
  sync_min: assert property (@(posedge clock) disable iff (reset)
    !sync && sync_run != 8'd0 |-> sync_run == 8'd16)
    else $error("sync fell before 16 cycles");

  // strobe is a single cycle
  ready_pulse: assert property (@(posedge clock) disable iff (reset)
    sample_ready |=> !sample_ready)
    else $error("sample_ready longer than one cycle");

  // link quiet while the codec is held
  hold_quiet: assert property (@(posedge clock) disable iff (reset)
    !audio_reset_b |-> !sync && !sdata_out && !sample_ready)
    else $error("link active while codec in reset");

endmodule

bind audio_codec_top audio_codec_chk u_chk (
  .clock(clock),
  .reset(reset),
  .audio_reset_b(audio_reset_b),
  .sync(sync),
  .sdata_out(sdata_out),
  .sample_ready(sample_ready)
);

// ==== sim/audio_codec_tb.sv ====
// testbench for the ac97 codec controller
// decodes the serial frames and compares them with a reference model
module audio_codec_tb
  import ac97_pkg::*;
#(
  parameter int NUM_FRAMES = 37
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLOCK_NS = 20;
  localparam int DEBOUNCE = 16;
  localparam int HOLD = 8;
  localparam int VOL_INIT = 8;
  // cycles for one button press and its release
  localparam int WINDOW = 80;
  // reset, hold, release and 40 frames
  localparam int WATCHDOG_CYCLES = 4 + HOLD + 1 + 40 * FRAME_BITS;

  logic clock;
  logic reset;
  logic button_up;
  logic button_down;
  logic [SAMPLE_WIDTH-1:0] audio_out_data;
  logic [SAMPLE_WIDTH-1:0] audio_in_data;
  logic sample_ready;
  logic audio_reset_b;
  logic sync;
  logic sdata_out;
  logic sdata_in;

  logic [31:0] rng;
  int errors;
  int frames_done;
  int frames_checked;
  // decoded frames with frame bit k at index 255-k
  logic [FRAME_BITS-1:0] seen_data [NUM_FRAMES];
  logic [FRAME_BITS-1:0] seen_sync [NUM_FRAMES];
  logic [FRAME_BITS-1:0] seen_ready [NUM_FRAMES];
  // model state at the end of each frame
  logic [VOLUME_WIDTH-1:0] vol_end [NUM_FRAMES];
  logic [SAMPLE_WIDTH-1:0] sample_sent [NUM_FRAMES];

  audio_codec_top #(
    .DEBOUNCE_COUNT(DEBOUNCE),
    .CODEC_RESET_CYCLES(HOLD),
    .VOLUME_AT_RESET(VOL_INIT)
  ) u_dut (
    .clock(clock),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .audio_out_data(audio_out_data),
    .audio_in_data(audio_in_data),
    .sample_ready(sample_ready),
    .audio_reset_b(audio_reset_b),
    .sync(sync),
    .sdata_out(sdata_out),
    .sdata_in(sdata_in)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_NS / 2) clock = ~clock;
  end

  ////////////////////////////////////////
  // helpers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // up presses when positive, down presses when negative
  function automatic int press_plan(input int idx);
    if (idx == 1) return 1;
    // climb past the top
    if (idx >= 4 && idx <= 13) return 3;
    // and down past the bottom
    if (idx >= 20 && idx <= 31) return -3;
    return 0;
  endfunction

  // pin level over one press window with contact bounce on both edges
  function automatic logic press_level(input int j);
    return (j <= 2) || (j == 5) || (j >= 8 && j <= 49) || (j == 52);
  endfunction

  function automatic logic [FRAME_BITS-1:0] expected_frame(
    input int idx,
    input logic [VOLUME_WIDTH-1:0] vol,
    input logic [SAMPLE_WIDTH-1:0] sample
  );
    logic [FRAME_BITS-1:0] f;
    logic [VOLUME_WIDTH-1:0] att;
    logic [23:0] cmd;
    f = '0;
    // frame valid is the only bit of frame 0
    f[FRAME_BITS-1] = 1'b1;
    if (idx > 0) begin
      att = VOLUME_WIDTH'(VOLUME_MAX) - vol;
      case (idx % CMD_STATES)
        3: cmd = {REG_HEADPHONE, 3'b000, att, 3'b000, att};
        5: cmd = {REG_PCM_VOL, PCM_VOL_DATA};
        6: cmd = {REG_REC_SELECT, 16'h0000};
        7: cmd = {REG_REC_GAIN, REC_GAIN_DATA};
        9: cmd = {REG_MIC, MIC_DATA};
        10: cmd = {REG_BEEP, BEEP_DATA};
        11: cmd = {REG_GENERAL, GENERAL_DATA};
        default: cmd = {REG_READ_ID, 16'h0000};
      endcase
      // command and both audio slots valid
      f[FRAME_BITS-2 -: 4] = 4'hF;
      f[FRAME_BITS-1-SLOT1_START -: SLOT_BITS] = {cmd[23:16], 12'h000};
      f[FRAME_BITS-1-SLOT2_START -: SLOT_BITS] = {cmd[15:0], 4'h0};
      f[FRAME_BITS-1-SLOT3_START -: SLOT_BITS] = {sample, 12'h000};
      f[FRAME_BITS-1-SLOT4_START -: SLOT_BITS] = {sample, 12'h000};
    end
    return f;
  endfunction

  task automatic check_value(input string name, input logic [FRAME_BITS-1:0] expected,
                             input logic [FRAME_BITS-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  ////////////////////////////////////////
  // stimulus and frame decoder
  ////////////////////////////////////////

  initial begin : stimulus
    int i;
    int idx;
    int k;
    int p;
    int presses;
    int n;
    logic [VOLUME_WIDTH-1:0] vol;
    logic [SLOT_BITS-1:0] word;
    logic level;
    reset = 1'b1;
    button_up = 1'b0;
    button_down = 1'b0;
    audio_out_data = '0;
    sdata_in = 1'b0;
    rng = 32'd6;
    errors = 0;
    frames_done = 0;
    // first rising edge opens the reset window
    @(posedge clock);
    repeat (4) begin
      @(negedge clock);
      check_value("reset outputs", '0, {audio_reset_b, sync, sdata_out, sample_ready});
    end
    reset = 1'b0;
    // codec held for HOLD cycles and released on the next one
    for (i = 1; i <= HOLD + 1; i++) begin
      @(negedge clock);
      check_value("codec release", i == HOLD + 1, audio_reset_b);
      check_value("hold outputs", '0, {sync, sdata_out, sample_ready});
    end
    vol = VOLUME_WIDTH'(VOL_INIT);
    for (idx = 0; idx < NUM_FRAMES; idx++) begin
      p = press_plan(idx);
      presses = p < 0 ? -p : p;
      // saturating volume model
      for (n = 0; n < presses; n++) begin
        if (p > 0 && vol != VOLUME_WIDTH'(VOLUME_MAX)) begin
          vol = vol + 1'b1;
        end else if (p < 0 && vol != '0) begin
          vol = vol - 1'b1;
        end
      end
      vol_end[idx] = vol;
      rng = xorshift(rng);
      sample_sent[idx] = rng[SAMPLE_WIDTH-1:0];
      rng = xorshift(rng);
      word = rng[SLOT_BITS-1:0];
      for (k = 0; k < FRAME_BITS; k++) begin
        @(negedge clock);
        // outputs show frame bit k here
        seen_data[idx][FRAME_BITS-1-k] = sdata_out;
        seen_sync[idx][FRAME_BITS-1-k] = sync;
        seen_ready[idx][FRAME_BITS-1-k] = sample_ready;
        if (k == READY_BIT) begin
          check_value($sformatf("frame %0d capture", idx),
                      word[SLOT_BITS-1 -: SAMPLE_WIDTH], audio_in_data);
        end
        // held for the whole frame and taken at its end
        if (k == 0) begin
          audio_out_data = sample_sent[idx];
        end
        // left input slot msb first
        if (k >= SLOT3_START && k < SLOT3_START + SLOT_BITS) begin
          sdata_in = word[SLOT3_START + SLOT_BITS - 1 - k];
        end else begin
          sdata_in = 1'b0;
        end
        level = k < 3 * WINDOW && k / WINDOW < presses && press_level(k % WINDOW);
        button_up = level && p > 0;
        button_down = level && p < 0;
      end
      frames_done = idx + 1;
    end
    wait (frames_checked == NUM_FRAMES);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  ////////////////////////////////////////
  // comparison
  ////////////////////////////////////////

  initial begin : compare
    logic [VOLUME_WIDTH-1:0] vol;
    logic [SAMPLE_WIDTH-1:0] sample;
    frames_checked = 0;
    forever begin
      wait (frames_done > frames_checked);
      // frame n carries what was set up during frame n-1
      vol = frames_checked == 0 ? '0 : vol_end[frames_checked-1];
      sample = frames_checked == 0 ? '0 : sample_sent[frames_checked-1];
      check_value($sformatf("frame %0d data", frames_checked),
                  expected_frame(frames_checked, vol, sample), seen_data[frames_checked]);
      check_value($sformatf("frame %0d sync", frames_checked),
                  {{TAG_BITS{1'b1}}, {(FRAME_BITS - TAG_BITS){1'b0}}},
                  seen_sync[frames_checked]);
      check_value($sformatf("frame %0d strobe", frames_checked),
                  FRAME_BITS'(1) << (FRAME_BITS - 1 - READY_BIT), seen_ready[frames_checked]);
      frames_checked++;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLOCK_NS);
    $display("timeout, frames stopped arriving after %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== project.f ====
hw/ac97_pkg.sv
hw/debounce.sv
hw/volume_control.sv
hw/ac97_command_seq.sv
hw/ac97_frame.sv
hw/audio_codec_top.sv
sim/audio_codec_chk.sv
sim/audio_codec_tb.sv

// ==== Makefile ====
# Verilator simulation of the ac97 codec controller
VERILATOR ?= verilator
TOP ?= audio_codec_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '>>> PASS' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
